// ==== commit_config.svh ====
// commit stage configuration, widths shared by the package and the RTL
`ifndef COMMIT_CONFIG_SVH
`define COMMIT_CONFIG_SVH

// ----------------------------------------
// datapath
// ----------------------------------------
// integer register and result width, rv32 only
`define COMMIT_XLEN 32

// architectural register index, x0..x31
`define COMMIT_REG_ADDR_W 5

// ----------------------------------------
// scoreboard
// ----------------------------------------
// transaction id handed back to the issue stage
`define COMMIT_TRANS_ID_W 3

// oldest two entries are looked at each cycle
`define COMMIT_NR_PORTS 2

// ----------------------------------------
// exceptions
// ----------------------------------------
// cause is a full xlen word, interrupt flag in the msb
`define COMMIT_CAUSE_W `COMMIT_XLEN

`endif

// ==== commit_pkg.sv ====
// commit stage package with unit, operation, exception and scoreboard entry types
`include "commit_config.svh"

package commit_pkg;

  // ----------------------------------------
  // functional unit of a scoreboard entry
  // ----------------------------------------
  typedef enum logic [3:0] {
    NONE      = 4'd0,
    LOAD      = 4'd1,
    STORE     = 4'd2,
    ALU       = 4'd3,
    CTRL_FLOW = 4'd4,
    MULT      = 4'd5,
    CSR       = 4'd6
  } fu_t;

  // ----------------------------------------
  // operation codes
  // ----------------------------------------
  // only the codes the commit stage looks at, plus a few plain ones
  typedef enum logic [7:0] {
    // add doubles as the csr no-op
    ADD       = 8'h00,
    ADDI      = 8'h01,
    LW        = 8'h10,
    SW        = 8'h11,
    CSR_WRITE = 8'h20,
    CSR_READ  = 8'h21,
    CSR_SET   = 8'h22,
    CSR_CLEAR = 8'h23,
    // fences wait for the store buffer to drain
    FENCE     = 8'h30,
    FENCE_I   = 8'h31
  } op_t;

  // ----------------------------------------
  // exception record
  // ----------------------------------------
  typedef struct packed {
    logic                         valid;
    logic [`COMMIT_CAUSE_W-1:0]   cause;
    // faulting address or instruction bits
    logic [`COMMIT_XLEN-1:0]      tval;
  } exception_t;

  // ----------------------------------------
  // scoreboard entry seen at commit
  // ----------------------------------------
  typedef struct packed {
    logic                         valid;
    logic [`COMMIT_XLEN-1:0]      pc;
    logic [`COMMIT_TRANS_ID_W-1:0] trans_id;
    fu_t                          fu;
    op_t                          op;
    logic [`COMMIT_REG_ADDR_W-1:0] rd;
    // alu result, or csr write value for csr entries
    logic [`COMMIT_XLEN-1:0]      result;
    exception_t                   ex;
  } sb_entry_t;

endpackage

// ==== commit_port_if.sv ====
// commit port interface, one scoreboard entry with its drop flag, ack and gpr write
`timescale 1ns/1ps
`include "commit_config.svh"

interface commit_port_if;

  // entry under commit and its cancel flag, from the issue side
  commit_pkg::sb_entry_t          entry;
  logic                           drop;

  // retire handshake back to the scoreboard
  logic                           ack;

  // integer register file write
  logic                           we_gpr;
  logic [`COMMIT_REG_ADDR_W-1:0]  waddr;
  logic [`COMMIT_XLEN-1:0]        wdata;

  // port controller view
  modport ctrl (
    input  entry, drop,
    output ack, we_gpr, waddr, wdata
  );

  // read-only view of another port, entry and its ack
  modport peer (
    input  entry, ack
  );

  // top level view, feeds the entry and collects the result
  modport top (
    output entry, drop,
    input  ack, we_gpr, waddr, wdata
  );

endinterface

// ==== commit_port0_ctrl.sv ====
// commit port 0 controller, retires the oldest entry and drives store, csr and fence control
`timescale 1ns/1ps
`include "commit_config.svh"

module commit_port0_ctrl (
  commit_port_if.ctrl                 port_if,
  // core halted by the debug or wfi logic
  input  logic                        halt_i,
  // store buffer can take another committed store
  input  logic                        commit_lsu_ready_i,
  // store buffer is empty
  input  logic                        no_st_pending_i,
  // read value of the addressed csr
  input  logic [`COMMIT_XLEN-1:0]     csr_rdata_i,
  // csr file refuses the access
  input  logic                        csr_exception_valid_i,
  output logic                        commit_lsu_o,
  output logic                        commit_csr_o,
  output commit_pkg::op_t             csr_op_o,
  output logic [`COMMIT_XLEN-1:0]     csr_wdata_o,
  output logic                        fence_o,
  output logic                        fence_i_o
);

  // destination register goes straight through
  assign port_if.waddr = port_if.entry.rd;

  // ----------------------------------------
  // commit decision
  // ----------------------------------------
  always_comb begin
    // nothing retires by default
    port_if.ack    = 1'b0;
    port_if.we_gpr = 1'b0;
    commit_lsu_o   = 1'b0;
    commit_csr_o   = 1'b0;
    fence_o        = 1'b0;
    fence_i_o      = 1'b0;
    // result unless the csr read value replaces it
    port_if.wdata  = port_if.entry.result;
    // csr no-op
    csr_op_o       = commit_pkg::ADD;
    csr_wdata_o    = '0;

    // halt freezes the head of the scoreboard
    if (port_if.entry.valid && !halt_i) begin
      if (port_if.entry.ex.valid) begin
        // faulting entry only leaves when it was cancelled
        if (port_if.drop) begin
          port_if.ack = 1'b1;
        end
      end else begin
        port_if.ack = 1'b1;

        // cancelled entries retire with no register update
        if (!port_if.drop) begin
          port_if.we_gpr = 1'b1;
        end

        // ----------------------------------------
        // store
        // ----------------------------------------
        // store becomes non-speculative only if the buffer has room
        if (port_if.entry.fu == commit_pkg::STORE) begin
          if (commit_lsu_ready_i) begin
            commit_lsu_o = 1'b1;
          end else begin
            // buffer full, keep the entry
            port_if.ack = 1'b0;
          end
        end

        // ----------------------------------------
        // csr
        // ----------------------------------------
        if (port_if.entry.fu == commit_pkg::CSR) begin
          csr_op_o    = port_if.entry.op;
          csr_wdata_o = port_if.entry.result;
          if (!port_if.drop) begin
            if (!csr_exception_valid_i) begin
              commit_csr_o  = 1'b1;
              // old csr value lands in rd
              port_if.wdata = csr_rdata_i;
            end else begin
              // access traps, the exception path takes over
              port_if.ack    = 1'b0;
              port_if.we_gpr = 1'b0;
            end
          end
        end

        // ----------------------------------------
        // fences
        // ----------------------------------------
        // both wait until the store buffer has drained
        if (port_if.entry.op == commit_pkg::FENCE_I) begin
          if (!port_if.drop) begin
            port_if.ack = no_st_pending_i;
            // icache flush request
            fence_i_o   = no_st_pending_i;
          end
        end

        if (port_if.entry.op == commit_pkg::FENCE) begin
          if (!port_if.drop) begin
            port_if.ack = no_st_pending_i;
            // dcache flush request
            fence_o     = no_st_pending_i;
          end
        end
      end
    end
  end

endmodule

// ==== commit_port1_ctrl.sv ====
// commit port 1 controller, retires the second entry alongside port 0 when allowed
`timescale 1ns/1ps
`include "commit_config.svh"

module commit_port1_ctrl (
  commit_port_if.ctrl  port_if,
  // port 0 entry and its ack
  commit_port_if.peer  peer_if,
  input  logic         halt_i,
  // debug single step, one instruction per step
  input  logic         single_step_i
);

  // units whose only effect is the register write
  logic fu_simple;

  // write port follows the entry, the enable decides
  assign port_if.waddr = port_if.entry.rd;
  assign port_if.wdata = port_if.entry.result;

  assign fu_simple = (port_if.entry.fu == commit_pkg::ALU)       ||
                     (port_if.entry.fu == commit_pkg::LOAD)      ||
                     (port_if.entry.fu == commit_pkg::CTRL_FLOW) ||
                     (port_if.entry.fu == commit_pkg::MULT);

  // ----------------------------------------
  // dual retire
  // ----------------------------------------
  always_comb begin
    port_if.ack    = 1'b0;
    port_if.we_gpr = 1'b0;

    // second entry only rides along with the head
    if (peer_if.ack && port_if.entry.valid && !halt_i && !single_step_i) begin
      // a csr at the head may change state the next entry depends on
      if ((peer_if.entry.fu != commit_pkg::CSR) && !port_if.entry.ex.valid && fu_simple) begin
        port_if.ack = 1'b1;
        // cancelled entries retire with no register update
        if (!port_if.drop) begin
          port_if.we_gpr = 1'b1;
        end
      end
    end
  end

endmodule

// ==== commit_exception_sel.sv ====
// commit exception select, picks the entry or csr exception of port 0 and masks it on halt
`timescale 1ns/1ps
`include "commit_config.svh"

module commit_exception_sel (
  // port 0 entry, ack not needed here
  commit_port_if.peer             peer_if,
  // port 0 cancel flag
  input  logic                    drop_i,
  input  logic                    halt_i,
  // exception raised by the csr file for the port 0 access
  input  commit_pkg::exception_t  csr_exception_i,
  output commit_pkg::exception_t  exception_o
);

  // ----------------------------------------
  // priority
  // ----------------------------------------
  // interrupts are ordered in the csr file, only sync traps are sorted here
  always_comb begin
    exception_o = '0;

    // needs a live, non-cancelled head entry
    if (peer_if.entry.valid && !drop_i) begin
      // csr fault, tval still holds the instruction bits from decode
      if (csr_exception_i.valid) begin
        exception_o      = csr_exception_i;
        exception_o.tval = peer_if.entry.ex.tval;
      end

      // earlier fault in the pipe wins, e.g. fetch page fault
      if (peer_if.entry.ex.valid) begin
        exception_o = peer_if.entry.ex;
      end
    end

    // halted core takes no trap
    if (halt_i) begin
      exception_o.valid = 1'b0;
    end
  end

endmodule

// ==== commit_stage.sv ====
// commit stage top, retires up to two scoreboard entries per cycle into the architectural state
`timescale 1ns/1ps
`include "commit_config.svh"

module commit_stage (
  // ----------------------------------------
  // scoreboard side
  // ----------------------------------------
  input  commit_pkg::sb_entry_t                commit_instr0_i,
  input  commit_pkg::sb_entry_t                commit_instr1_i,
  // per-port cancel, retire with no effect
  input  logic [`COMMIT_NR_PORTS-1:0]          commit_drop_i,
  output logic [`COMMIT_NR_PORTS-1:0]          commit_ack_o,
  output logic [`COMMIT_TRANS_ID_W-1:0]        commit_tran_id_o,
  // ----------------------------------------
  // control
  // ----------------------------------------
  input  logic                                 halt_i,
  input  logic                                 single_step_i,
  output commit_pkg::exception_t               exception_o,
  output logic [`COMMIT_XLEN-1:0]              pc_o,
  output logic                                 fence_o,
  output logic                                 fence_i_o,
  // ----------------------------------------
  // register file
  // ----------------------------------------
  output logic [`COMMIT_REG_ADDR_W-1:0]        waddr0_o,
  output logic [`COMMIT_REG_ADDR_W-1:0]        waddr1_o,
  output logic [`COMMIT_XLEN-1:0]              wdata0_o,
  output logic [`COMMIT_XLEN-1:0]              wdata1_o,
  output logic [`COMMIT_NR_PORTS-1:0]          we_gpr_o,
  // ----------------------------------------
  // load/store unit
  // ----------------------------------------
  input  logic                                 commit_lsu_ready_i,
  input  logic                                 no_st_pending_i,
  output logic                                 commit_lsu_o,
  // ----------------------------------------
  // csr file
  // ----------------------------------------
  input  logic [`COMMIT_XLEN-1:0]              csr_rdata_i,
  input  commit_pkg::exception_t               csr_exception_i,
  output logic                                 commit_csr_o,
  output commit_pkg::op_t                      csr_op_o,
  output logic [`COMMIT_XLEN-1:0]              csr_wdata_o
);

  // one bundle per commit port
  commit_port_if port0_if ();
  commit_port_if port1_if ();

  // feed the oldest two entries in
  assign port0_if.entry = commit_instr0_i;
  assign port0_if.drop  = commit_drop_i[0];
  assign port1_if.entry = commit_instr1_i;
  assign port1_if.drop  = commit_drop_i[1];

  // head entry info for the frontend and the issue stage
  assign pc_o             = commit_instr0_i.pc;
  assign commit_tran_id_o = commit_instr0_i.trans_id;

  // ----------------------------------------
  // port controllers
  // ----------------------------------------
  commit_port0_ctrl u_port0_ctrl (
    .port_if               (port0_if.ctrl),
    .halt_i                (halt_i),
    .commit_lsu_ready_i    (commit_lsu_ready_i),
    .no_st_pending_i       (no_st_pending_i),
    .csr_rdata_i           (csr_rdata_i),
    .csr_exception_valid_i (csr_exception_i.valid),
    .commit_lsu_o          (commit_lsu_o),
    .commit_csr_o          (commit_csr_o),
    .csr_op_o              (csr_op_o),
    .csr_wdata_o           (csr_wdata_o),
    .fence_o               (fence_o),
    .fence_i_o             (fence_i_o)
  );

  // port 1 watches port 0 through the peer view
  commit_port1_ctrl u_port1_ctrl (
    .port_if       (port1_if.ctrl),
    .peer_if       (port0_if.peer),
    .halt_i        (halt_i),
    .single_step_i (single_step_i)
  );

  commit_exception_sel u_exception_sel (
    .peer_if         (port0_if.peer),
    .drop_i          (port0_if.drop),
    .halt_i          (halt_i),
    .csr_exception_i (csr_exception_i),
    .exception_o     (exception_o)
  );

  // collect the per-port results
  assign commit_ack_o = {port1_if.ack, port0_if.ack};
  assign we_gpr_o     = {port1_if.we_gpr, port0_if.we_gpr};
  assign waddr0_o     = port0_if.waddr;
  assign waddr1_o     = port1_if.waddr;
  assign wdata0_o     = port0_if.wdata;
  assign wdata1_o     = port1_if.wdata;

endmodule

// ==== tb_commit_stage.sv ====
// commit stage testbench, replays stimulus vectors and checks the retire decisions of both ports
`timescale 1ns/1ps
`include "commit_config.svh"

module tb_commit_stage;

  // values per stimulus line, inputs first, then expected outputs
  localparam int NCOL      = 37;
  // end marker has to show up within this many lines
  localparam int MAX_LINES = 200;

  logic                              clk_i;
  logic                              arst_n_i;

  // ----------------------------------------
  // dut signals
  // ----------------------------------------
  commit_pkg::sb_entry_t             commit_instr0_i;
  commit_pkg::sb_entry_t             commit_instr1_i;
  logic [`COMMIT_NR_PORTS-1:0]       commit_drop_i;
  logic                              halt_i;
  logic                              single_step_i;
  logic                              commit_lsu_ready_i;
  logic                              no_st_pending_i;
  logic [`COMMIT_XLEN-1:0]           csr_rdata_i;
  commit_pkg::exception_t            csr_exception_i;
  logic [`COMMIT_NR_PORTS-1:0]       commit_ack_o;
  logic [`COMMIT_REG_ADDR_W-1:0]     waddr0_o;
  logic [`COMMIT_REG_ADDR_W-1:0]     waddr1_o;
  logic [`COMMIT_XLEN-1:0]           wdata0_o;
  logic [`COMMIT_XLEN-1:0]           wdata1_o;
  logic [`COMMIT_NR_PORTS-1:0]       we_gpr_o;
  logic [`COMMIT_XLEN-1:0]           pc_o;
  logic [`COMMIT_TRANS_ID_W-1:0]     commit_tran_id_o;
  commit_pkg::exception_t            exception_o;
  logic                              commit_lsu_o;
  logic                              commit_csr_o;
  commit_pkg::op_t                   csr_op_o;
  logic [`COMMIT_XLEN-1:0]           csr_wdata_o;
  logic                              fence_o;
  logic                              fence_i_o;

  // one parsed stimulus line
  logic [31:0]                       col [0:NCOL-1];
  logic [8*128-1:0]                  line;
  // first token of a line, long enough for the end marker
  logic [23:0]                       word;
  integer                            fd;
  integer                            code;
  int                                n_line;
  int                                n_vec;
  logic                              done;

  commit_stage dut0 (
    .commit_instr0_i    (commit_instr0_i),
    .commit_instr1_i    (commit_instr1_i),
    .commit_drop_i      (commit_drop_i),
    .commit_ack_o       (commit_ack_o),
    .commit_tran_id_o   (commit_tran_id_o),
    .halt_i             (halt_i),
    .single_step_i      (single_step_i),
    .exception_o        (exception_o),
    .pc_o               (pc_o),
    .fence_o            (fence_o),
    .fence_i_o          (fence_i_o),
    .waddr0_o           (waddr0_o),
    .waddr1_o           (waddr1_o),
    .wdata0_o           (wdata0_o),
    .wdata1_o           (wdata1_o),
    .we_gpr_o           (we_gpr_o),
    .commit_lsu_ready_i (commit_lsu_ready_i),
    .no_st_pending_i    (no_st_pending_i),
    .commit_lsu_o       (commit_lsu_o),
    .csr_rdata_i        (csr_rdata_i),
    .csr_exception_i    (csr_exception_i),
    .commit_csr_o       (commit_csr_o),
    .csr_op_o           (csr_op_o),
    .csr_wdata_o        (csr_wdata_o)
  );

  // 8 ns clock, only paces the vectors
  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  task automatic stop_on_failure;
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_on_failure;
    end
  endtask

  // idle bus, nothing valid
  task automatic clear_inputs;
    commit_instr0_i    = '0;
    commit_instr1_i    = '0;
    commit_drop_i      = '0;
    halt_i             = 1'b0;
    single_step_i      = 1'b0;
    commit_lsu_ready_i = 1'b0;
    no_st_pending_i    = 1'b0;
    csr_rdata_i        = '0;
    csr_exception_i    = '0;
  endtask

  // with no valid entry every control output stays quiet
  task automatic check_idle;
    check_value("commit_ack_o[0]", 32'(commit_ack_o[0]), 32'd0);
    check_value("commit_ack_o[1]", 32'(commit_ack_o[1]), 32'd0);
    check_value("we_gpr_o[0]", 32'(we_gpr_o[0]), 32'd0);
    check_value("we_gpr_o[1]", 32'(we_gpr_o[1]), 32'd0);
    check_value("commit_lsu_o", 32'(commit_lsu_o), 32'd0);
    check_value("commit_csr_o", 32'(commit_csr_o), 32'd0);
    check_value("fence_o", 32'(fence_o), 32'd0);
    check_value("fence_i_o", 32'(fence_i_o), 32'd0);
    check_value("exception_o.valid", 32'(exception_o.valid), 32'd0);
  endtask

  // port 1 retires only beside the head and only for plain units
  function automatic logic port1_ack_expected();
    logic [3:0] fu0;
    logic [3:0] fu1;
    logic       unit_ok;
    fu0     = col[3][3:0];
    fu1     = col[11][3:0];
    unit_ok = (fu1 == commit_pkg::ALU) || (fu1 == commit_pkg::LOAD) ||
              (fu1 == commit_pkg::CTRL_FLOW) || (fu1 == commit_pkg::MULT);
    port1_ack_expected = col[25][0] && col[10][0] && !col[18][0] && !col[19][0] &&
                         (fu0 != commit_pkg::CSR) && !col[15][0] && unit_ok;
  endfunction

  // ----------------------------------------
  // vector drive and check
  // ----------------------------------------
  task automatic drive_vector;
    // cols 0..9 port 0 entry
    commit_instr0_i          = '0;
    commit_instr0_i.valid    = col[0][0];
    commit_instr0_i.pc       = col[1];
    commit_instr0_i.trans_id = col[2][2:0];
    commit_instr0_i.fu       = commit_pkg::fu_t'(col[3][3:0]);
    commit_instr0_i.op       = commit_pkg::op_t'(col[4][7:0]);
    commit_instr0_i.rd       = col[5][4:0];
    commit_instr0_i.result   = col[6];
    commit_instr0_i.ex.valid = col[7][0];
    commit_instr0_i.ex.cause = col[8];
    commit_instr0_i.ex.tval  = col[9];
    // cols 10..15 port 1 entry, the next instruction in program order
    commit_instr1_i          = '0;
    commit_instr1_i.valid    = col[10][0];
    commit_instr1_i.pc       = col[1] + 32'd4;
    commit_instr1_i.trans_id = col[2][2:0] + 3'd1;
    commit_instr1_i.fu       = commit_pkg::fu_t'(col[11][3:0]);
    commit_instr1_i.op       = commit_pkg::op_t'(col[12][7:0]);
    commit_instr1_i.rd       = col[13][4:0];
    commit_instr1_i.result   = col[14];
    commit_instr1_i.ex.valid = col[15][0];
    // cols 16..21 drop and core control
    commit_drop_i            = {col[16][0], col[17][0]};
    halt_i                   = col[18][0];
    single_step_i            = col[19][0];
    commit_lsu_ready_i       = col[20][0];
    no_st_pending_i          = col[21][0];
    // cols 22..24 csr file answer, its tval must never reach the output
    csr_rdata_i              = col[22];
    csr_exception_i.valid    = col[23][0];
    csr_exception_i.cause    = col[24];
    csr_exception_i.tval     = 32'hbad0_0bad;
  endtask

  task automatic check_vector;
    logic ack1_exp;
    ack1_exp = port1_ack_expected();
    // cols 25..36 expected values
    check_value("commit_ack_o[0]", 32'(commit_ack_o[0]), col[25]);
    check_value("we_gpr_o[0]", 32'(we_gpr_o[0]), col[26]);
    check_value("waddr0_o", 32'(waddr0_o), 32'(commit_instr0_i.rd));
    // write data is a don't care while the write is off
    if (col[26][0]) begin
      check_value("wdata0_o", wdata0_o, col[27]);
    end
    check_value("commit_lsu_o", 32'(commit_lsu_o), col[28]);
    check_value("commit_csr_o", 32'(commit_csr_o), col[29]);
    check_value("csr_op_o", 32'(csr_op_o), col[30]);
    check_value("csr_wdata_o", csr_wdata_o, col[31]);
    check_value("fence_o", 32'(fence_o), col[32]);
    check_value("fence_i_o", 32'(fence_i_o), col[33]);
    check_value("exception_o.valid", 32'(exception_o.valid), col[34]);
    if (col[34][0]) begin
      check_value("exception_o.cause", exception_o.cause, col[35]);
      check_value("exception_o.tval", exception_o.tval, col[36]);
    end
    // port 1 write goes only where its own drop bit allows
    check_value("commit_ack_o[1]", 32'(commit_ack_o[1]), 32'(ack1_exp));
    check_value("we_gpr_o[1]", 32'(we_gpr_o[1]), 32'(ack1_exp && !col[16][0]));
    check_value("waddr1_o", 32'(waddr1_o), 32'(col[13][4:0]));
    check_value("wdata1_o", wdata1_o, col[14]);
    // head entry info is plain wiring
    check_value("pc_o", pc_o, commit_instr0_i.pc);
    check_value("commit_tran_id_o", 32'(commit_tran_id_o), 32'(commit_instr0_i.trans_id));
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    clear_inputs;
    arst_n_i = 1'b0;
    // reset for 5 cycles, outputs checked just before release
    repeat (4) @(posedge clk_i);
    #7;
    check_idle;
    @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    fd = $fopen("commit_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file commit_stimulus.txt");
      stop_on_failure;
    end

    done   = 1'b0;
    n_line = 0;
    n_vec  = 0;
    while (!done && n_line < MAX_LINES) begin
      n_line = n_line + 1;
      code   = $fgets(line, fd);
      if (code == 0) begin
        $display("stimulus file ended before its end marker");
        stop_on_failure;
      end
      word = '0;
      code = $sscanf(line, "%s", word);
      if (word == "end") begin
        done = 1'b1;
      end else begin
        code = $sscanf(line,
          "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
          col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
          col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
          col[16], col[17], col[18], col[19], col[20], col[21], col[22], col[23],
          col[24], col[25], col[26], col[27], col[28], col[29], col[30], col[31],
          col[32], col[33], col[34], col[35], col[36]);
        if (code == NCOL) begin
          // drive after the edge, sample just before the next one
          @(posedge clk_i);
          #1;
          drive_vector;
          #6;
          check_vector;
          n_vec = n_vec + 1;
        end else if (code > 0) begin
          $display("stimulus line %0d has %0d values instead of %0d", n_line, code, NCOL);
          stop_on_failure;
        end
      end
    end
    $fclose(fd);

    if (!done) begin
      $display("no end marker within %0d stimulus lines", MAX_LINES);
      stop_on_failure;
    end

    if (n_vec > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("stimulus file holds no vectors");
      stop_on_failure;
    end
  end

endmodule

// ==== commit_stimulus.txt ====
// in  v0 pc tid fu op rd res exv cause tval  v1 fu op rd res exv  dr1 dr0 halt step rdy nsp
// then crd cexv ccause  expect ack0 we0 wd0 lsu csr cop cwd fence fence_i exv cause tval
1 100 1 3 01 5 2a 0 0 0  1 3 01 6 3b 0  0 0 0 0 1 1  0 0 0  1 1 2a 0 0 00 0 0 0 0 0 0
1 104 2 5 00 3 1c 0 0 0  1 4 00 0 0 0  0 0 0 0 1 1  0 0 0  1 1 1c 0 0 00 0 0 0 0 0 0
1 108 3 3 01 7 11 0 0 0  1 3 01 8 22 0  1 1 0 0 1 1  0 0 0  1 0 11 0 0 00 0 0 0 0 0 0
1 10c 4 2 11 0 0 0 0 0  1 1 10 6 3b 0  0 0 0 0 0 1  0 0 0  0 1 0 0 0 00 0 0 0 0 0 0
1 10c 4 2 11 0 0 0 0 0  1 1 10 6 3b 0  0 0 0 0 1 1  0 0 0  1 1 0 1 0 00 0 0 0 0 0 0
1 110 5 6 20 9 55 0 0 0  1 3 01 6 3b 0  0 0 0 0 1 1  77 0 0  1 1 77 0 1 20 55 0 0 0 0 0
1 114 6 6 22 a 55 0 0 342  1 3 01 6 3b 0  0 0 0 0 1 1  77 1 2  0 0 55 0 0 22 55 0 0 1 2 342
1 118 7 6 21 b 55 0 0 342  1 3 01 6 3b 0  0 1 0 0 1 1  77 1 2  1 0 55 0 0 21 55 0 0 0 0 0
1 11c 0 6 23 c 0f 0 0 0  1 3 01 6 3b 0  0 0 0 0 1 1  0 0 0  1 1 0 0 1 23 f 0 0 0 0 0
1 120 1 0 30 0 0 0 0 0  1 3 01 6 3b 0  0 0 0 0 1 0  0 0 0  0 1 0 0 0 00 0 0 0 0 0 0
1 120 1 0 30 0 0 0 0 0  1 3 01 6 3b 0  0 0 0 0 1 1  0 0 0  1 1 0 0 0 00 0 1 0 0 0 0
1 124 2 0 31 0 0 0 0 0  1 3 01 6 3b 0  0 0 0 0 1 0  0 0 0  0 1 0 0 0 00 0 0 0 0 0 0
1 124 2 0 31 0 0 0 0 0  1 3 01 6 3b 0  0 0 0 0 1 1  0 0 0  1 1 0 0 0 00 0 0 1 0 0 0
1 128 3 1 10 d 0 1 5 1234  1 3 01 6 3b 0  0 0 0 0 1 1  0 1 2  0 0 0 0 0 00 0 0 0 1 5 1234
1 128 3 1 10 d 0 1 5 1234  1 3 01 6 3b 0  0 1 0 0 1 1  0 1 2  1 0 0 0 0 00 0 0 0 0 0 0
1 100 1 3 01 5 2a 0 0 0  1 3 01 6 3b 0  0 0 1 0 1 1  0 0 0  0 0 2a 0 0 00 0 0 0 0 0 0
1 128 3 1 10 d 0 1 5 1234  1 3 01 6 3b 0  0 0 1 0 1 1  0 1 2  0 0 0 0 0 00 0 0 0 0 0 0
1 100 1 3 01 5 2a 0 0 0  1 3 01 6 3b 0  0 0 0 1 1 1  0 0 0  1 1 2a 0 0 00 0 0 0 0 0 0
0 130 5 3 01 5 2a 0 0 0  0 3 01 6 3b 0  0 0 0 0 1 1  0 1 2  0 0 0 0 0 00 0 0 0 0 0 0
end

// ==== commit_stage.f ====
+incdir+.
commit_pkg.sv
commit_port_if.sv
commit_port0_ctrl.sv
commit_port1_ctrl.sv
commit_exception_sel.sv
commit_stage.sv
tb_commit_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the commit stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f commit_stage.f \
  --top-module tb_commit_stage -o sim_commit_stage
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_commit_stage > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
echo "simulation finished cleanly"
exit 0
